// File: sources.f
logic/frv_pkg.sv
logic/frv_interrupt.sv
logic/frv_counters.sv
logic/frv_csr.sv
logic/frv_core_ctrl.sv
sim/frv_clkgen.sv
sim/frv_checker.sv
sim/frv_tb.sv

// File: sim/frv_tb.sv
// --------------------------------------------------------------------------
// Testbench for the machine-mode control subsystem
// Drives the CSR port, retire, interrupt lines, trap handshake and the
// Wishbone timer port, and checks the responses with assertions
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frv_tb import frv_pkg::*; ();

  localparam int drive_delay    = 1;    // ns after the rising edge
  localparam int timeout_cycles = 2000; // About four times the full run
  localparam int trap_wait      = 120;  // Longest wait for a trap request
  localparam int wb_wait        = 8;    // Longest wait for ack or err

  logic        g_clk;
  logic        reset;
  csr_req_t    csr_req;
  logic [31:0] csr_rdata;
  logic        instr_ret;
  trap_req_t   trap;
  logic        trap_ack;
  logic [31:0] trap_pc;
  logic        mret;
  logic        int_nmi;
  logic        int_external;
  logic [3:0]  int_extern_cause;
  logic        int_software;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;

  integer      seed = 92;     // Interrupt arrival gaps
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          test_errors;   // Error count when the test started
  int          cycle_count = 0;
  string       test_name;
  logic [31:0] rd_a;
  logic [31:0] rd_b;
  logic [5:0]  cause;
  logic [3:0]  ext_k;

  frv_clkgen clkgen (.g_clk(g_clk), .reset(reset));

  frv_core_ctrl DUT (
    .g_clk           (g_clk           ),
    .reset           (reset           ),
    .csr_req         (csr_req         ),
    .csr_rdata       (csr_rdata       ),
    .instr_ret       (instr_ret       ),
    .trap            (trap            ),
    .trap_ack        (trap_ack        ),
    .trap_pc         (trap_pc         ),
    .mret            (mret            ),
    .int_nmi         (int_nmi         ),
    .int_external    (int_external    ),
    .int_extern_cause(int_extern_cause),
    .int_software    (int_software    ),
    .wb_req          (wb_req          ),
    .wb_rsp          (wb_rsp          )
  );

  always @(posedge g_clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  function automatic int total_errors();
    return errors + DUT.u_checker.fail_count; // Includes bound assertions
  endfunction

  task automatic next_cycle();
    @(posedge g_clk);
    #drive_delay;
  endtask

  task automatic check_eq(input string what, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = total_errors();
  endtask

  task automatic end_test();
    if (total_errors() == test_errors) begin
      tests_passed++;
      $display("Test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d error(s)", test_name, total_errors() - test_errors);
    end
  endtask

  // ------------------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------------------
  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    next_cycle();
    csr_req = '{valid: 1'b1, we: 1'b1, addr: addr, wdata: data};
    next_cycle(); // Taken at this edge
    csr_req = '0;
  endtask

  task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
    next_cycle();
    csr_req = '{valid: 1'b1, we: 1'b0, addr: addr, wdata: 32'd0};
    @(negedge g_clk);
    data = csr_rdata; // Combinational, stable mid-cycle
    next_cycle();
    csr_req = '0;
  endtask

  task automatic wb_access(input logic we, input logic [31:0] adr,
                           input logic [31:0] dat, input logic [3:0] sel,
                           output wb_rsp_t rsp);
    int n;
    next_cycle();
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    n = 0;
    @(negedge g_clk);
    while (!(wb_rsp.ack || wb_rsp.err) && n < wb_wait) begin
      @(negedge g_clk);
      n++;
    end
    rsp = wb_rsp;
    if (!(rsp.ack || rsp.err)) begin
      $display("Wishbone access to %h got neither ack nor err", adr);
      errors++;
    end
    next_cycle(); // Request held until the response
    wb_req = '0;
  endtask

  task automatic wb_read_check(input string what, input logic [31:0] adr,
                               input logic [31:0] exp);
    wb_rsp_t rsp;
    wb_access(1'b0, adr, 32'd0, 4'h0, rsp);
    check_eq({what, " ack"}, rsp.ack, 1'b1);
    check_eq({what, " data"}, rsp.dat, exp);
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel);
    wb_rsp_t rsp;
    wb_access(1'b1, adr, dat, sel, rsp);
    check_eq("Wishbone write ack", rsp.ack, 1'b1);
  endtask

  task automatic wb_expect_err(input logic [31:0] adr);
    wb_rsp_t rsp;
    wb_access(1'b0, adr, 32'd0, 4'hF, rsp);
    check_eq("Bad address err", rsp.err, 1'b1);
    check_eq("Bad address ack", rsp.ack, 1'b0);
    check_eq("Bad address data", rsp.dat, 32'd0);
  endtask

  task automatic retire(input int n);
    repeat (n) begin
      next_cycle();
      instr_ret = 1'b1;
      next_cycle();
      instr_ret = 1'b0;
    end
  endtask

  task automatic pulse_int(input logic nmi, input logic ext, input logic [3:0] ecause,
                           input logic sw);
    int gap;
    gap = $unsigned($random(seed)) % 4; // Random arrival
    repeat (gap) next_cycle();
    next_cycle();
    int_nmi          = nmi;
    int_external     = ext;
    int_extern_cause = ecause;
    int_software     = sw;
    next_cycle();
    int_nmi      = 1'b0;
    int_external = 1'b0;
    int_software = 1'b0;
  endtask

  task automatic ack_trap(input logic [31:0] pc, output logic [5:0] got_cause);
    int n;
    n = 0;
    @(negedge g_clk);
    while (!trap.req && n < trap_wait) begin
      @(negedge g_clk);
      n++;
    end
    got_cause = trap.cause;
    if (!trap.req) begin
      $display("No trap request arrived within %0d cycles", trap_wait);
      errors++;
    end else begin
      next_cycle();
      trap_ack = 1'b1;
      trap_pc  = pc;
      next_cycle();
      trap_ack = 1'b0;
    end
  endtask

  task automatic expect_no_trap(input int cycles);
    repeat (cycles) begin
      @(negedge g_clk);
      check_eq("Unexpected trap request", trap.req, 1'b0);
    end
  endtask

  task automatic pulse_mret();
    next_cycle();
    mret = 1'b1;
    next_cycle();
    mret = 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    csr_req          = '0;
    instr_ret        = 1'b0;
    trap_ack         = 1'b0;
    trap_pc          = '0;
    mret             = 1'b0;
    int_nmi          = 1'b0;
    int_external     = 1'b0;
    int_extern_cause = '0;
    int_software     = 1'b0;
    wb_req           = '0;
    @(negedge reset);
    next_cycle();

    start_test("reset state");
    @(negedge g_clk);
    check_eq("Trap request after reset", trap.req, 1'b0);
    wb_read_check("mtimecmp lo", mmio_base_addr + mmio_mtimecmp_lo, 32'hFFFF_FFFF);
    wb_read_check("mtimecmp hi", mmio_base_addr + mmio_mtimecmp_hi, 32'hFFFF_FFFF);
    csr_read(csr_mstatus, rd_a);
    check_eq("mstatus", rd_a, 32'd0);
    end_test();

    start_test("counters");
    csr_read(csr_minstret, rd_a);
    retire(5);
    csr_read(csr_minstret, rd_b);
    check_eq("minstret after 5 retires", rd_b, rd_a + 32'd5);
    csr_write(csr_mcountinhibit, 32'h1); // Stop mcycle
    csr_read(csr_mcycle, rd_a);
    csr_read(csr_mcycle, rd_b);
    check_eq("Inhibited mcycle", rd_b, rd_a);
    csr_write(csr_mcountinhibit, 32'h0);
    csr_read(csr_mcycle, rd_a);
    csr_read(csr_mcycle, rd_b);
    check_eq("mcycle advance between reads", rd_b - rd_a, 32'd2); // Reads 2 cycles apart
    end_test();

    start_test("wishbone timer");
    wb_write(mmio_base_addr + mmio_mtimecmp_lo, 32'h1234_5678, 4'hF);
    wb_read_check("mtimecmp lo", mmio_base_addr + mmio_mtimecmp_lo, 32'h1234_5678);
    wb_write(mmio_base_addr + mmio_mtimecmp_lo, 32'hAABB_CCDD, 4'b0010); // Byte 1 only
    wb_read_check("Masked mtimecmp lo", mmio_base_addr + mmio_mtimecmp_lo, 32'h1234_CC78);
    wb_expect_err(32'h0000_2000); // Outside the region
    wb_expect_err(mmio_base_addr + 32'h010); // Unused offset
    end_test();

    start_test("timer trap");
    csr_write(csr_mie, 32'h0000_0080);     // mtie
    csr_write(csr_mstatus, 32'h0000_0008); // mie
    begin
      wb_rsp_t rsp;
      wb_access(1'b0, mmio_base_addr + mmio_mtime_lo, 32'd0, 4'h0, rsp);
      rd_a = rsp.dat;
    end
    wb_write(mmio_base_addr + mmio_mtimecmp_hi, 32'd0, 4'hF);
    wb_write(mmio_base_addr + mmio_mtimecmp_lo, rd_a + 32'd40, 4'hF);
    ack_trap(32'h0000_2468, cause);
    check_eq("Timer trap cause", cause, cause_mti);
    csr_read(csr_mcause, rd_a);
    check_eq("mcause", rd_a, 32'h8000_0007);
    csr_read(csr_mepc, rd_a);
    check_eq("mepc", rd_a, 32'h0000_2468);
    csr_read(csr_mstatus, rd_a);
    check_eq("mstatus after trap", rd_a, 32'h0000_0080); // mpie set, mie clear
    end_test();

    start_test("mret");
    pulse_mret();
    csr_read(csr_mstatus, rd_a);
    check_eq("mstatus after mret", rd_a, 32'h0000_0088);
    ack_trap(32'h0000_2470, cause); // Timer is still pending
    check_eq("Second timer trap cause", cause, cause_mti);
    wb_write(mmio_base_addr + mmio_mtimecmp_hi, 32'hFFFF_FFFF, 4'hF);
    csr_write(csr_mie, 32'd0);
    end_test();

    start_test("priority and nmi");
    ext_k = $random(seed);
    csr_write(csr_mie, 32'h0000_0808);     // meie and msie
    csr_write(csr_mstatus, 32'h0000_0008);
    pulse_int(1'b0, 1'b1, ext_k, 1'b1);
    ack_trap(32'h0000_3000, cause);
    check_eq("External over software", cause, 32'd16 + ext_k);
    csr_read(csr_mcause, rd_a);
    check_eq("mcause external", rd_a, 32'h8000_0000 | (32'd16 + ext_k));
    csr_write(csr_mstatus, 32'd0);         // Global enable off
    pulse_int(1'b0, 1'b1, ext_k, 1'b1);
    expect_no_trap(6);
    pulse_int(1'b1, 1'b0, 4'd0, 1'b0);
    ack_trap(32'h0000_3100, cause);
    check_eq("NMI cause", cause, cause_nmi);
    end_test();

    next_cycle();
    $display("Tests passed %0d, failed %0d, errors %0d",
             tests_passed, tests_failed, total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/frv_checker.sv
// --------------------------------------------------------------------------
// Protocol checker for the machine-mode control top level
// Wishbone response rules, trap request hold and the state after reset
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frv_checker import frv_pkg::*; (
  input logic      g_clk,
  input logic      reset,
  input trap_req_t trap,
  input logic      trap_ack,
  input wb_req_t   wb_req,
  input wb_rsp_t   wb_rsp
);

  int unsigned fail_count = 0; // Assertion failures so far

  // ------------------------------------------------------------------------
  // Wishbone timer port
  // ------------------------------------------------------------------------
  ack_err_exclusive: assert property (@(posedge g_clk) disable iff (reset)
    !(wb_rsp.ack && wb_rsp.err))
    else begin
      fail_count++;
      $error("Wishbone ack and err high in the same cycle");
    end

  rsp_after_req: assert property (@(posedge g_clk) disable iff (reset)
    (wb_rsp.ack || wb_rsp.err) |-> $past(wb_req.cyc && wb_req.stb))
    else begin
      fail_count++;
      $error("Wishbone response without a preceding cyc and stb");
    end

  // ------------------------------------------------------------------------
  // Trap handshake and reset state
  // ------------------------------------------------------------------------
  trap_hold: assert property (@(posedge g_clk) disable iff (reset)
    (trap.req && !trap_ack) |=> (trap.req && $stable(trap.cause)))
    else begin
      fail_count++;
      $error("Trap request dropped or cause changed before trap_ack");
    end

  quiet_after_reset: assert property (@(posedge g_clk)
    $fell(reset) |-> (!trap.req && !wb_rsp.ack && !wb_rsp.err))
    else begin
      fail_count++;
      $error("Trap request or Wishbone response in the first cycle after reset");
    end

endmodule

bind frv_core_ctrl frv_checker u_checker (
  .g_clk   (g_clk   ),
  .reset   (reset   ),
  .trap    (trap    ),
  .trap_ack(trap_ack),
  .wb_req  (wb_req  ),
  .wb_rsp  (wb_rsp  )
);

`default_nettype wire

// File: sim/frv_clkgen.sv
// --------------------------------------------------------------------------
// Testbench clock and reset generator
// 10 ns clock, reset held high for the first 4 rising edges
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frv_clkgen (
  output logic g_clk,
  output logic reset
);

  localparam int half_period  = 5; // 10 ns period
  localparam int reset_cycles = 4;

  initial begin
    g_clk = 1'b0;
    forever #half_period g_clk = ~g_clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge g_clk);
    #1 reset = 1'b0; // Released with the other inputs
  end

endmodule

`default_nettype wire

// File: logic/frv_core_ctrl.sv
// --------------------------------------------------------------------------
// Core machine-mode control top level
// Joins the CSR unit, the interrupt unit and the counters with their timer
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frv_core_ctrl import frv_pkg::*; (
  input  logic        g_clk,
  input  logic        reset,
  input  csr_req_t    csr_req,          // From the pipeline
  output logic [31:0] csr_rdata,
  input  logic        instr_ret,        // Instruction retired
  output trap_req_t   trap,             // Interrupt trap request
  input  logic        trap_ack,         // Pipeline took the trap
  input  logic [31:0] trap_pc,
  input  logic        mret,
  input  logic        int_nmi,
  input  logic        int_external,
  input  logic [3:0]  int_extern_cause,
  input  logic        int_software,
  input  wb_req_t     wb_req,           // Timer MMIO port
  output wb_rsp_t     wb_rsp
);

  // ------------------------------------------------------------------------
  // Internal wiring
  // ------------------------------------------------------------------------
  int_enable_t  enable;      // mstatus.mie and mie
  int_pending_t pending;     // mip
  ctr_inhibit_t inhibit;     // mcountinhibit
  logic [63:0]  ctr_cycle;
  logic [63:0]  ctr_time;
  logic [63:0]  ctr_instret;
  logic         ti_pending;  // Timer compare hit

  frv_csr i_csr (
    .g_clk      (g_clk      ),
    .reset      (reset      ),
    .csr_req    (csr_req    ),
    .csr_rdata  (csr_rdata  ),
    .pending    (pending    ),
    .enable     (enable     ),
    .inhibit    (inhibit    ),
    .ctr_cycle  (ctr_cycle  ),
    .ctr_time   (ctr_time   ),
    .ctr_instret(ctr_instret),
    .trap       (trap       ), // Cause for mcause
    .trap_ack   (trap_ack   ),
    .trap_pc    (trap_pc    ),
    .mret       (mret       )
  );

  frv_interrupt i_interrupt (
    .g_clk      (g_clk           ),
    .reset      (reset           ),
    .enable     (enable          ),
    .nmi_pending(int_nmi         ),
    .ex_pending (int_external    ),
    .ex_cause   (int_extern_cause),
    .ti_pending (ti_pending      ), // From the counters
    .sw_pending (int_software    ),
    .pending    (pending         ),
    .trap       (trap            ),
    .trap_ack   (trap_ack        )
  );

  frv_counters i_counters (
    .g_clk          (g_clk      ),
    .reset          (reset      ),
    .instr_ret      (instr_ret  ),
    .inhibit        (inhibit    ),
    .ctr_cycle      (ctr_cycle  ),
    .ctr_time       (ctr_time   ),
    .ctr_instret    (ctr_instret),
    .timer_interrupt(ti_pending ),
    .wb_req         (wb_req     ),
    .wb_rsp         (wb_rsp     )
  );

endmodule

`default_nettype wire

// File: logic/frv_csr.sv
// --------------------------------------------------------------------------
// Machine CSR unit
// mstatus, mie, mepc, mcause and mcountinhibit, read-only mip and counter
// views, and the trap entry and mret state changes
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frv_csr import frv_pkg::*; (
  input  logic         g_clk,
  input  logic         reset,
  input  csr_req_t     csr_req,
  output logic [31:0]  csr_rdata,   // Valid while csr_req.valid
  input  int_pending_t pending,     // mip from the interrupt unit
  output int_enable_t  enable,
  output ctr_inhibit_t inhibit,
  input  logic [63:0]  ctr_cycle,
  input  logic [63:0]  ctr_time,
  input  logic [63:0]  ctr_instret,
  input  trap_req_t    trap,        // Cause of the acknowledged trap
  input  logic         trap_ack,
  input  logic [31:0]  trap_pc,
  input  logic         mret
);

  logic        mstatus_mie;
  logic        mstatus_mpie;
  logic        mie_meie;
  logic        mie_mtie;
  logic        mie_msie;
  logic [31:0] mepc;
  logic [31:0] mcause;
  logic        csr_wr;
  logic [11:0] addr;
  logic [31:0] wdata;
  logic [31:0] rd_mux;

  assign csr_wr = csr_req.valid && csr_req.we;
  assign addr   = csr_req.addr;
  assign wdata  = csr_req.wdata;

  // ------------------------------------------------------------------------
  // State updates
  // ------------------------------------------------------------------------
  always_ff @(posedge g_clk) begin
    if (reset) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
    end else if (trap_ack) begin
      mstatus_mpie <= mstatus_mie; // Trap entry wins over a CSR write
      mstatus_mie  <= 1'b0;
    end else if (mret) begin
      mstatus_mie  <= mstatus_mpie;
      mstatus_mpie <= 1'b1;
    end else if (csr_wr && addr == csr_mstatus) begin
      mstatus_mie  <= wdata[3];
      mstatus_mpie <= wdata[7];
    end
  end

  always_ff @(posedge g_clk) begin
    if (reset) begin
      mepc   <= '0;
      mcause <= '0;
    end else if (trap_ack) begin
      mepc   <= trap_pc;
      mcause <= {trap.req, 25'd0, trap.cause}; // Bit 31 marks interrupt
    end else if (csr_wr) begin
      if (addr == csr_mepc) begin
        mepc <= {wdata[31:1], 1'b0}; // IALIGN 16
      end
      if (addr == csr_mcause) begin
        mcause <= wdata;
      end
    end
  end

  always_ff @(posedge g_clk) begin
    if (reset) begin
      mie_meie <= 1'b0;
      mie_mtie <= 1'b0;
      mie_msie <= 1'b0;
      inhibit  <= '0;
    end else if (csr_wr) begin
      if (addr == csr_mie) begin
        mie_meie <= wdata[11];
        mie_mtie <= wdata[7];
        mie_msie <= wdata[3];
      end
      if (addr == csr_mcountinhibit) begin
        inhibit.cy <= wdata[0];
        inhibit.tm <= wdata[1];
        inhibit.ir <= wdata[2];
      end
    end
  end

  assign enable.mstatus_mie = mstatus_mie;
  assign enable.meie        = mie_meie;
  assign enable.mtie        = mie_mtie;
  assign enable.msie        = mie_msie;

  // ------------------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------------------
  always_comb begin
    rd_mux = '0; // Unknown addresses read zero
    case (addr)
      csr_mstatus:       rd_mux = {24'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};
      csr_mie:           rd_mux = {20'd0, mie_meie, 3'd0, mie_mtie, 3'd0, mie_msie, 3'd0};
      csr_mip: begin
        rd_mux = {20'd0, pending.meip, 3'd0, pending.mtip, 3'd0, pending.msip, 3'd0};
      end
      csr_mepc:          rd_mux = mepc;
      csr_mcause:        rd_mux = mcause;
      csr_mcountinhibit: rd_mux = {29'd0, inhibit.ir, inhibit.tm, inhibit.cy};
      csr_mcycle:        rd_mux = ctr_cycle[31:0];
      csr_mcycleh:       rd_mux = ctr_cycle[63:32];
      csr_minstret:      rd_mux = ctr_instret[31:0];
      csr_minstreth:     rd_mux = ctr_instret[63:32];
      csr_time:          rd_mux = ctr_time[31:0];
      csr_timeh:         rd_mux = ctr_time[63:32];
      default:           rd_mux = '0;
    endcase
  end

  assign csr_rdata = csr_req.valid ? rd_mux : '0;

endmodule

`default_nettype wire

// File: logic/frv_counters.sv
// --------------------------------------------------------------------------
// Counters and memory-mapped timer
// cycle, time and instret counters, the mtimecmp compare and a Wishbone
// classic slave for mtime and mtimecmp
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frv_counters import frv_pkg::*; (
  input  logic         g_clk,
  input  logic         reset,
  input  logic         instr_ret,       // Retire pulse
  input  ctr_inhibit_t inhibit,         // From mcountinhibit
  output logic [63:0]  ctr_cycle,
  output logic [63:0]  ctr_time,        // Doubles as mtime
  output logic [63:0]  ctr_instret,
  output logic         timer_interrupt, // mtime >= mtimecmp
  input  wb_req_t      wb_req,
  output wb_rsp_t      wb_rsp
);

  logic [63:0] mtimecmp;
  logic        wb_take;   // New access this cycle
  logic        in_region;
  logic [11:0] offset;
  logic        offset_ok;
  logic        hit;       // Valid timer register
  logic        wr_en;
  logic [31:0] rd_word;   // Current addressed word
  logic [31:0] wr_word;   // After byte merge

  function automatic logic [31:0] byte_merge(
    input logic [31:0] old_word,
    input logic [31:0] new_word,
    input logic [3:0]  sel
  );
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  // ------------------------------------------------------------------------
  // Wishbone decode
  // ------------------------------------------------------------------------
  assign wb_take   = wb_req.cyc && wb_req.stb && !(wb_rsp.ack || wb_rsp.err);
  assign in_region = (wb_req.adr & mmio_base_mask) == mmio_base_addr;
  assign offset    = wb_req.adr[11:0];

  always_comb begin
    offset_ok = 1'b1;
    rd_word   = '0;
    case (offset)
      mmio_mtime_lo:    rd_word = ctr_time[31:0];
      mmio_mtime_hi:    rd_word = ctr_time[63:32];
      mmio_mtimecmp_lo: rd_word = mtimecmp[31:0];
      mmio_mtimecmp_hi: rd_word = mtimecmp[63:32];
      default:          offset_ok = 1'b0; // Unused offset
    endcase
  end

  assign hit     = in_region && offset_ok;
  assign wr_en   = wb_take && wb_req.we && hit;
  assign wr_word = byte_merge(rd_word, wb_req.dat, wb_req.sel);

  // Single cycle registered response
  always_ff @(posedge g_clk) begin
    if (reset) begin
      wb_rsp <= '0;
    end else begin
      wb_rsp.ack <= wb_take && hit;
      wb_rsp.err <= wb_take && !hit;
      wb_rsp.dat <= (wb_take && hit && !wb_req.we) ? rd_word : '0;
    end
  end

  // ------------------------------------------------------------------------
  // Counters
  // ------------------------------------------------------------------------
  always_ff @(posedge g_clk) begin
    if (reset) begin
      ctr_time <= '0;
    end else if (wr_en && offset == mmio_mtime_lo) begin
      ctr_time[31:0] <= wr_word; // Write beats the increment
    end else if (wr_en && offset == mmio_mtime_hi) begin
      ctr_time[63:32] <= wr_word;
    end else if (!inhibit.tm) begin
      ctr_time <= ctr_time + 64'd1;
    end
  end

  always_ff @(posedge g_clk) begin
    if (reset) begin
      mtimecmp <= '1; // No timer interrupt out of reset
    end else if (wr_en && offset == mmio_mtimecmp_lo) begin
      mtimecmp[31:0] <= wr_word;
    end else if (wr_en && offset == mmio_mtimecmp_hi) begin
      mtimecmp[63:32] <= wr_word;
    end
  end

  always_ff @(posedge g_clk) begin
    if (reset) begin
      ctr_cycle   <= '0;
      ctr_instret <= '0;
    end else begin
      if (!inhibit.cy) begin
        ctr_cycle <= ctr_cycle + 64'd1;
      end
      if (instr_ret && !inhibit.ir) begin
        ctr_instret <= ctr_instret + 64'd1;
      end
    end
  end

  assign timer_interrupt = ctr_time >= mtimecmp; // Combinational compare

endmodule

`default_nettype wire

// File: logic/frv_interrupt.sv
// --------------------------------------------------------------------------
// Interrupt unit
// Registers the interrupt lines into mip, masks them with the enables and
// holds one prioritised trap request until it is acknowledged
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frv_interrupt import frv_pkg::*; (
  input  logic         g_clk,
  input  logic         reset,
  input  int_enable_t  enable,      // From mstatus and mie
  input  logic         nmi_pending, // Non-maskable line
  input  logic         ex_pending,  // External line
  input  logic [3:0]   ex_cause,    // External cause code
  input  logic         ti_pending,  // From the timer compare
  input  logic         sw_pending,  // Software line
  output int_pending_t pending,     // mip view
  output trap_req_t    trap,
  input  logic         trap_ack
);

  logic       nmi_q;      // Registered NMI line
  logic [3:0] ex_cause_q; // Cause sampled with meip
  logic       ext_req;
  logic       sw_req;
  logic       tim_req;
  trap_req_t  next_trap;  // Winner of this cycle

  // ------------------------------------------------------------------------
  // Source registers
  // ------------------------------------------------------------------------
  always_ff @(posedge g_clk) begin
    if (reset) begin
      pending <= '0;
      nmi_q   <= 1'b0;
    end else begin
      pending.meip <= ex_pending;
      pending.mtip <= ti_pending;
      pending.msip <= sw_pending;
      nmi_q        <= nmi_pending;
    end
  end

  always_ff @(posedge g_clk) begin
    ex_cause_q <= ex_cause; // Travels with meip
  end

  // Maskable sources need the global enable as well
  assign ext_req = pending.meip && enable.meie && enable.mstatus_mie;
  assign sw_req  = pending.msip && enable.msie && enable.mstatus_mie;
  assign tim_req = pending.mtip && enable.mtie && enable.mstatus_mie;

  // Fixed priority NMI, external, software, timer
  always_comb begin
    next_trap = '0;
    if (nmi_q) begin
      next_trap.req   = 1'b1;
      next_trap.cause = cause_nmi;
    end else if (ext_req) begin
      next_trap.req   = 1'b1;
      next_trap.cause = cause_mei_base + {2'b00, ex_cause_q};
    end else if (sw_req) begin
      next_trap.req   = 1'b1;
      next_trap.cause = cause_msi;
    end else if (tim_req) begin
      next_trap.req   = 1'b1;
      next_trap.cause = cause_mti;
    end
  end

  // ------------------------------------------------------------------------
  // Request hold
  // ------------------------------------------------------------------------
  always_ff @(posedge g_clk) begin
    if (reset) begin
      trap <= '0;
    end else if (trap.req) begin
      if (trap_ack) begin
        trap.req <= 1'b0; // Cause kept, new pick next cycle
      end
    end else begin
      trap <= next_trap;
    end
  end

endmodule

`default_nettype wire

// File: logic/frv_pkg.sv
// --------------------------------------------------------------------------
// Machine-mode control package
// Timer MMIO map, CSR addresses, interrupt cause codes and the packed
// structs that travel between the CSR unit, interrupts and counters
// --------------------------------------------------------------------------
`default_nettype none

package frv_pkg;

  // ------------------------------------------------------------------------
  // Timer MMIO region
  // ------------------------------------------------------------------------
  localparam logic [31:0] mmio_base_addr   = 32'h0000_1000; // 4 KiB window
  localparam logic [31:0] mmio_base_mask   = 32'hFFFF_F000;

  localparam logic [11:0] mmio_mtime_lo    = 12'h000; // Word offsets
  localparam logic [11:0] mmio_mtime_hi    = 12'h004;
  localparam logic [11:0] mmio_mtimecmp_lo = 12'h008;
  localparam logic [11:0] mmio_mtimecmp_hi = 12'h00C;

  // ------------------------------------------------------------------------
  // Machine CSR addresses
  // ------------------------------------------------------------------------
  localparam logic [11:0] csr_mstatus       = 12'h300;
  localparam logic [11:0] csr_mie           = 12'h304;
  localparam logic [11:0] csr_mcountinhibit = 12'h320;
  localparam logic [11:0] csr_mepc          = 12'h341;
  localparam logic [11:0] csr_mcause        = 12'h342;
  localparam logic [11:0] csr_mip           = 12'h344;
  localparam logic [11:0] csr_mcycle        = 12'hB00;
  localparam logic [11:0] csr_minstret      = 12'hB02;
  localparam logic [11:0] csr_mcycleh       = 12'hB80;
  localparam logic [11:0] csr_minstreth     = 12'hB82;
  localparam logic [11:0] csr_time          = 12'hC01; // User read-only view
  localparam logic [11:0] csr_timeh         = 12'hC81;

  // Interrupt cause codes
  localparam logic [5:0] cause_nmi      = 6'd0;
  localparam logic [5:0] cause_msi      = 6'd3;
  localparam logic [5:0] cause_mti      = 6'd7;
  localparam logic [5:0] cause_mei_base = 6'd16; // Plus 4-bit external cause

  // ------------------------------------------------------------------------
  // Shared structs
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t; // Wishbone classic master to slave

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t; // Wishbone classic slave to master

  typedef struct packed {
    logic        valid;
    logic        we;
    logic [11:0] addr;
    logic [31:0] wdata;
  } csr_req_t; // CSR access port

  typedef struct packed {
    logic mstatus_mie; // Global enable
    logic meie;
    logic mtie;
    logic msie;
  } int_enable_t;

  typedef struct packed {
    logic meip;
    logic mtip;
    logic msip;
  } int_pending_t; // Registered mip bits

  typedef struct packed {
    logic cy;
    logic tm;
    logic ir;
  } ctr_inhibit_t; // mcountinhibit bits

  typedef struct packed {
    logic       req;
    logic [5:0] cause;
  } trap_req_t;

endpackage

`default_nettype wire
